// File: vlog.f
sram_alloc_pkg.sv
sram_status_table.sv
sram_scan.sv
port_wr_sram_matcher.sv
port_wr_alloc_ctrl.sv
sram_alloc_top.sv
tb_sram_alloc.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_sram_alloc \
    -f vlog.f \
    -o tb_sram_alloc_sim

out=$(./obj_dir/tb_sram_alloc_sim)
echo "$out"

# The run counts as passed only when the testbench printed its pass line.
if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: tb_sram_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sram_alloc;
    import sram_alloc_pkg::*;

    localparam int PAGES      = 256;
    localparam int N_ENTRIES  = 18;
    localparam int GRANT_WAIT = 50;

    logic clk;
    logic rst_n;
    wr_req_t req;
    logic req_valid;
    logic req_ready;
    wr_grant_t grant;
    logic grant_valid;
    logic grant_ready;
    rel_req_t rel;
    logic rel_valid;
    tick_t match_threshold;
    logic [NUM_SRAMS-1:0] sram_lock;

    // Stimulus and expectation table, one row per request.
    pkt_len_t len_tab [N_ENTRIES];
    port_id_t port_tab [N_ENTRIES];
    logic [31:0] lock_tab [N_ENTRIES];
    tick_t thr_tab [N_ENTRIES];
    logic rel_tab [N_ENTRIES];
    sram_id_t rel_sram_tab [N_ENTRIES];
    port_id_t rel_port_tab [N_ENTRIES];
    pages_t rel_pages_tab [N_ENTRIES];
    int exp_tab [N_ENTRIES];
    int stall_tab [N_ENTRIES];
    int n_entries;

    // Reference copy of the free pages and the packet counts.
    int model_free [NUM_SRAMS];
    int model_cnt [NUM_SRAMS][NUM_PORTS];

    int seed;
    int errors;
    int checks;
    int budget_cycles;
    logic stuck;

    sram_alloc_top #(.PAGES_PER_SRAM(PAGES)) uut (
        .clk, .rst_n, .req, .req_valid, .req_ready,
        .grant, .grant_valid, .grant_ready,
        .rel, .rel_valid, .match_threshold, .sram_lock
    );

    always #5 clk = ~clk;

    // A packet occupies its length in eighths, rounded down, plus one page.
    function automatic int page_count_for(input int len);
        return len / 8 + 1;
    endfunction

    // Best eligible bank among 0 up to the threshold, later bank on a tie.
    function automatic int pick_bank(input int need, input int port,
                                     input logic [31:0] lock, input int thr);
        int best;
        int best_cnt;
        best = -1;
        best_cnt = 0;
        for (int b = 0; b <= thr; b++) begin
            if (!lock[b] && model_free[b] >= need && model_cnt[b][port] >= best_cnt) begin
                best = b;
                best_cnt = model_cnt[b][port];
            end
        end
        return best;
    endfunction

    task automatic add_entry(input int len, input int port, input logic [31:0] lock,
                             input int thr, input int rel_on, input int rel_sram,
                             input int rel_port, input int rel_pages, input int exp);
        len_tab[n_entries] = pkt_len_t'(len);
        port_tab[n_entries] = port_id_t'(port);
        lock_tab[n_entries] = lock;
        thr_tab[n_entries] = tick_t'(thr);
        rel_tab[n_entries] = (rel_on != 0);
        rel_sram_tab[n_entries] = sram_id_t'(rel_sram);
        rel_port_tab[n_entries] = port_id_t'(rel_port);
        rel_pages_tab[n_entries] = pages_t'(rel_pages);
        exp_tab[n_entries] = exp;
        n_entries = n_entries + 1;
    endtask

    // --------------------
    // Table contents.
    // --------------------

    task automatic build_table;
        // Fresh banks and clustering per port.
        add_entry(20, 0, 32'h0, 31, 0, 0, 0, 0, 31);
        add_entry(100, 0, 32'h0, 31, 0, 0, 0, 0, 31);
        add_entry(7, 1, 32'h0, 31, 0, 0, 0, 0, 31);
        add_entry(50, 2, 32'h8000_0000, 31, 0, 0, 0, 0, 30);
        add_entry(8, 2, 32'h0, 31, 0, 0, 0, 0, 30);
        // Bank 31 fills up with 64-page packets until it drops out.
        add_entry(511, 0, 32'h0, 31, 0, 0, 0, 0, 31);
        add_entry(511, 0, 32'h0, 31, 0, 0, 0, 0, 31);
        add_entry(511, 0, 32'h0, 31, 0, 0, 0, 0, 31);
        add_entry(511, 0, 32'h0, 31, 0, 0, 0, 0, 30);
        add_entry(16, 0, 32'h0, 31, 0, 0, 0, 0, 31);
        // Releases reopen bank 31 and shift port 2 over to bank 29.
        add_entry(511, 0, 32'h0, 31, 1, 31, 0, 64, 31);
        add_entry(40, 2, 32'hC000_0000, 31, 0, 0, 0, 0, 29);
        add_entry(40, 2, 32'hC000_0000, 31, 0, 0, 0, 0, 29);
        add_entry(8, 2, 32'h0, 31, 1, 30, 2, 7, 29);
        // A threshold of 3 limits the scan to banks 0 to 3.
        add_entry(30, 3, 32'h0, 3, 0, 0, 0, 0, 3);
        add_entry(30, 3, 32'h0000_0008, 3, 0, 0, 0, 0, 2);
        add_entry(9, 3, 32'h0, 3, 0, 0, 0, 0, 3);
        add_entry(9, 3, 32'h0, 31, 0, 0, 0, 0, 3);
    endtask

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    // Runs one table row from the release to the end of the commit.
    task automatic run_entry(input int i);
        int need;
        int exp;
        int waited;
        int err_before;
        wr_grant_t held;
        err_before = errors;
        sram_lock = lock_tab[i];
        match_threshold = thr_tab[i];
        if (rel_tab[i]) begin
            rel.sram = rel_sram_tab[i];
            rel.port = rel_port_tab[i];
            rel.pages = rel_pages_tab[i];
            rel_valid = 1'b1;
            step();
            rel_valid = 1'b0;
            model_free[rel_sram_tab[i]] = model_free[rel_sram_tab[i]] + int'(rel_pages_tab[i]);
            model_cnt[rel_sram_tab[i]][rel_port_tab[i]] =
                model_cnt[rel_sram_tab[i]][rel_port_tab[i]] - 1;
        end
        need = page_count_for(int'(len_tab[i]));
        exp = pick_bank(need, int'(port_tab[i]), lock_tab[i], int'(thr_tab[i]));
        checks = checks + 1;
        if (exp != exp_tab[i]) begin
            $display("ERR %0t: entry %0d model bank %0d, table bank %0d", $time, i, exp,
                     exp_tab[i]);
            errors = errors + 1;
        end
        // The controller is idle here, so the request goes in at the next edge.
        checks = checks + 1;
        if (!req_ready) begin
            $display("ERR %0t: entry %0d req_ready low while idle", $time, i);
            errors = errors + 1;
        end
        req.length = len_tab[i];
        req.port = port_tab[i];
        req_valid = 1'b1;
        step();
        req_valid = 1'b0;
        waited = 0;
        while (!grant_valid && waited < GRANT_WAIT) begin
            step();
            waited = waited + 1;
        end
        if (!grant_valid) begin
            $display("entry %0d: no grant came within %0d cycles of the request", i, GRANT_WAIT);
            errors = errors + 1;
            stuck = 1'b1;
        end else begin
            held = grant;
            checks = checks + 2;
            if (int'(grant.sram) != exp) begin
                $display("ERR %0t: entry %0d grant bank %0d, expected %0d", $time, i,
                         grant.sram, exp);
                errors = errors + 1;
            end
            if (int'(grant.pages) != need) begin
                $display("ERR %0t: entry %0d grant pages %0d, expected %0d", $time, i,
                         grant.pages, need);
                errors = errors + 1;
            end
            // The grant must hold still while the requester stalls.
            for (int s = 0; s < stall_tab[i]; s++) begin
                step();
                checks = checks + 1;
                if (!grant_valid || grant != held) begin
                    $display("ERR %0t: entry %0d grant moved during stall", $time, i);
                    errors = errors + 1;
                end
            end
            grant_ready = 1'b1;
            step();
            grant_ready = 1'b0;
            model_free[exp] = model_free[exp] - need;
            model_cnt[exp][port_tab[i]] = model_cnt[exp][port_tab[i]] + 1;
            checks = checks + 2;
            if (grant_valid) begin
                $display("ERR %0t: entry %0d grant still valid after handshake", $time, i);
                errors = errors + 1;
            end
            step();
            if (!req_ready || grant_valid) begin
                $display("ERR %0t: entry %0d controller not idle after commit", $time, i);
                errors = errors + 1;
            end
        end
        $display("entry %0d: port %0d len %0d bank %0d stall %0d %s", i, port_tab[i],
                 len_tab[i], exp, stall_tab[i], (errors == err_before) ? "ok" : "bad");
    endtask

    // --------------------
    // Watchdog.
    // --------------------

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("watchdog ran out after %0d cycles, the run did not finish", budget_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        req_valid = 1'b0;
        grant_ready = 1'b0;
        rel = '0;
        rel_valid = 1'b0;
        match_threshold = tick_t'(31);
        sram_lock = '0;
        seed = 97;
        errors = 0;
        checks = 0;
        stuck = 1'b0;
        n_entries = 0;
        build_table();
        // Each row gets up to 7 stall cycles and 60 cycles of slack on top.
        for (int i = 0; i < N_ENTRIES; i++) begin
            stall_tab[i] = $unsigned($random(seed)) % 8;
        end
        for (int b = 0; b < NUM_SRAMS; b++) begin
            model_free[b] = PAGES;
            for (int p = 0; p < NUM_PORTS; p++) begin
                model_cnt[b][p] = 0;
            end
        end
        budget_cycles = 16 + 20 + N_ENTRIES * 60;
        for (int i = 0; i < N_ENTRIES; i++) begin
            budget_cycles = budget_cycles + stall_tab[i];
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        checks = checks + 1;
        if (!req_ready || grant_valid) begin
            $display("ERR %0t: wrong handshake levels after reset", $time);
            errors = errors + 1;
        end
        for (int i = 0; i < n_entries; i++) begin
            if (!stuck) begin
                run_entry(i);
            end
        end
        $display("entries %0d, checks %0d, errors %0d", n_entries, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sram_alloc_top.sv
`timescale 1ns/1ns
`default_nettype none

module sram_alloc_top #(
    parameter int unsigned PAGES_PER_SRAM = 256
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // Write request.
    input  sram_alloc_pkg::wr_req_t              req,
    input  logic                                req_valid,
    output logic                                req_ready,
    // Grant.
    output sram_alloc_pkg::wr_grant_t            grant,
    output logic                                grant_valid,
    input  logic                                grant_ready,
    // Release, applied on arrival.
    input  sram_alloc_pkg::rel_req_t             rel,
    input  logic                                rel_valid,
    // Run-time settings.
    input  sram_alloc_pkg::tick_t                match_threshold,
    input  logic [sram_alloc_pkg::NUM_SRAMS-1:0] sram_lock
);
    import sram_alloc_pkg::*;

    // Controller to matcher and table.
    logic       match_enable;
    logic       xfer_ready;
    pkt_len_t   new_length;
    port_id_t   cur_port;
    logic       commit_valid;
    wr_grant_t  commit;
    port_id_t   commit_port;

    // Scanner, table and matcher results.
    sram_id_t   match_sram;
    logic       accessible;
    pages_t     free_space;
    pkt_count_t packet_amount;
    logic       match_suc;
    best_sram_t match_best_sram;

    port_wr_alloc_ctrl u_ctrl (
        .clk, .rst_n, .req, .req_valid, .req_ready,
        .grant, .grant_valid, .grant_ready,
        .match_enable, .xfer_ready, .new_length, .cur_port,
        .match_suc, .match_best_sram,
        .commit_valid, .commit, .commit_port
    );

    sram_scan u_scan (
        .clk, .rst_n, .match_enable, .match_threshold, .match_sram
    );

    port_wr_sram_matcher u_matcher (
        .clk, .rst_n, .match_threshold, .new_length, .match_enable,
        .xfer_ready, .match_suc, .match_sram, .match_best_sram,
        .accessible, .free_space, .packet_amount
    );

    sram_status_table #(
        .PAGES_PER_SRAM(PAGES_PER_SRAM)
    ) u_table (
        .clk, .rst_n, .sram_lock, .match_sram, .cur_port,
        .accessible, .free_space, .packet_amount,
        .commit_valid, .commit, .commit_port, .rel_valid, .rel
    );

endmodule

`default_nettype wire

// File: port_wr_alloc_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module port_wr_alloc_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    // Write request.
    input  sram_alloc_pkg::wr_req_t    req,
    input  logic                       req_valid,
    output logic                       req_ready,
    // Grant to the requester.
    output sram_alloc_pkg::wr_grant_t  grant,
    output logic                       grant_valid,
    input  logic                       grant_ready,
    // Matcher control.
    output logic                       match_enable,
    output logic                       xfer_ready,
    output sram_alloc_pkg::pkt_len_t   new_length,
    output sram_alloc_pkg::port_id_t   cur_port,
    input  logic                       match_suc,
    input  sram_alloc_pkg::best_sram_t match_best_sram,
    // Commit to the status table.
    output logic                       commit_valid,
    output sram_alloc_pkg::wr_grant_t  commit,
    output sram_alloc_pkg::port_id_t   commit_port
);
    import sram_alloc_pkg::*;

    alloc_state_t state;
    wr_req_t      req_q;
    wr_grant_t    grant_q;

    // --------------------
    // Sequencing.
    // --------------------

    // One request is in flight at a time.
    // The commit state lasts exactly one cycle after the handshake.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= alloc_idle;
        end else begin
            case (state)
                alloc_idle:   if (req_valid) state <= alloc_match;
                alloc_match:  if (match_suc) state <= alloc_grant;
                alloc_grant:  if (grant_ready) state <= alloc_commit;
                default:      state <= alloc_idle;
            endcase
        end
    end

    // The request is latched on acceptance and held for the match.
    always_ff @(posedge clk) begin
        if (state == alloc_idle && req_valid) begin
            req_q <= req;
        end
    end

    // The winning bank is captured one cycle after the success pulse.
    always_ff @(posedge clk) begin
        if (state == alloc_match && match_suc) begin
            grant_q.sram  <= match_best_sram[4:0];
            grant_q.pages <= pages_needed(req_q.length);
        end
    end

    // --------------------
    // Outputs.
    // --------------------

    // Matching stays on through the grant so the matcher holds its result.
    assign req_ready    = (state == alloc_idle);
    assign match_enable = (state == alloc_match) || (state == alloc_grant);
    assign grant_valid  = (state == alloc_grant);
    assign xfer_ready   = (state == alloc_commit);
    assign commit_valid = (state == alloc_commit);

    assign new_length  = req_q.length;
    assign cur_port    = req_q.port;
    assign grant       = grant_q;
    assign commit      = grant_q;
    assign commit_port = req_q.port;

endmodule

`default_nettype wire

// File: port_wr_sram_matcher.sv
`timescale 1ns/1ns
`default_nettype none

module port_wr_sram_matcher (
    input  logic                       clk,
    input  logic                       rst_n,
    input  sram_alloc_pkg::tick_t      match_threshold,
    // Request side.
    input  sram_alloc_pkg::pkt_len_t   new_length,
    input  logic                       match_enable,
    input  logic                       xfer_ready,
    output logic                       match_suc,
    // Status table side, for the bank under scan.
    input  sram_alloc_pkg::sram_id_t   match_sram,
    output sram_alloc_pkg::best_sram_t match_best_sram,
    input  logic                       accessible,
    input  sram_alloc_pkg::pages_t     free_space,
    input  sram_alloc_pkg::pkt_count_t packet_amount
);
    import sram_alloc_pkg::*;

    // Idle, scanning, or holding a result until the grant is taken.
    typedef enum logic [1:0] {
        m_idle,
        m_matching,
        m_done
    } match_state_t;

    match_state_t match_state;
    tick_t        match_tick;
    logic         match_find;
    pkt_count_t   max_amount;
    logic         eligible;
    logic         scoring;

    // --------------------
    // Scoring.
    // --------------------

    // A bank qualifies when it is unlocked and has room for the packet.
    assign eligible = accessible && (free_space >= pages_needed(new_length));

    // The best bank is frozen once the match is done.
    assign scoring = match_enable && !xfer_ready && (match_state != m_done);

    // The >= comparison lets the later scanned bank win a tie.
    always_ff @(posedge clk) begin
        if (!rst_n || !match_enable || xfer_ready) begin
            match_find      <= 1'b0;
            max_amount      <= '0;
            match_best_sram <= NO_SRAM;
        end else if (scoring && eligible && packet_amount >= max_amount) begin
            match_find      <= 1'b1;
            max_amount      <= packet_amount;
            match_best_sram <= best_sram_t'(match_sram);
        end
    end

    // --------------------
    // Tick and state.
    // --------------------

    // The tick counts enabled cycles and wraps at the threshold.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_tick <= '0;
        end else if (match_enable && match_tick != match_threshold) begin
            match_tick <= match_tick + tick_t'(1);
        end else begin
            match_tick <= '0;
        end
    end

    // Success needs both the threshold tick and a candidate in hand.
    // Without a candidate the scan simply goes round again.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_state <= m_idle;
            match_suc   <= 1'b0;
        end else begin
            match_suc <= 1'b0;
            case (match_state)
                m_idle: begin
                    if (match_enable) begin
                        match_state <= m_matching;
                    end
                end
                m_matching: begin
                    if (!match_enable) begin
                        match_state <= m_idle;
                    end else if (match_find && match_tick == match_threshold) begin
                        match_suc   <= 1'b1;
                        match_state <= m_done;
                    end
                end
                default: begin
                    // Held until the controller drops the enable.
                    if (!match_enable) begin
                        match_state <= m_idle;
                    end
                end
            endcase
        end
    end

    a_suc_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        match_suc |=> !match_suc);

    a_suc_has_bank : assert property (@(posedge clk) disable iff (!rst_n)
        match_suc |-> match_best_sram < NO_SRAM);

endmodule

`default_nettype wire

// File: sram_scan.sv
`timescale 1ns/1ns
`default_nettype none

module sram_scan (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     match_enable,
    input  sram_alloc_pkg::tick_t    match_threshold,
    output sram_alloc_pkg::sram_id_t match_sram
);
    import sram_alloc_pkg::*;

    logic at_threshold;

    // --------------------
    // Bank walk.
    // --------------------

    // The index runs in step with the match tick of the matcher.
    // It wraps at the threshold, so a short threshold narrows the scan
    // to banks 0 up to the threshold.
    assign at_threshold = (match_sram == sram_id_t'(match_threshold));

    // While matching is off the index rests at bank 0.
    // Each new match therefore starts its scan there.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_sram <= '0;
        end else if (match_enable && !at_threshold) begin
            match_sram <= match_sram + sram_id_t'(1);
        end else begin
            // Wrap at the threshold, or park at bank 0 when disabled.
            match_sram <= '0;
        end
    end

    // With the full threshold of 31 the walk covers every bank once per window.
    // That also follows from the 5-bit wrap of the index.

endmodule

`default_nettype wire

// File: sram_status_table.sv
`timescale 1ns/1ns
`default_nettype none

module sram_status_table #(
    parameter int unsigned PAGES_PER_SRAM = 256
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // External lock state, one bit per bank.
    input  logic [sram_alloc_pkg::NUM_SRAMS-1:0] sram_lock,
    // Lookup for the bank under scan.
    input  sram_alloc_pkg::sram_id_t             match_sram,
    input  sram_alloc_pkg::port_id_t             cur_port,
    output logic                                accessible,
    output sram_alloc_pkg::pages_t               free_space,
    output sram_alloc_pkg::pkt_count_t           packet_amount,
    // Commit of a granted packet.
    input  logic                                commit_valid,
    input  sram_alloc_pkg::wr_grant_t            commit,
    input  sram_alloc_pkg::port_id_t             commit_port,
    // Release of a departed packet.
    input  logic                                rel_valid,
    input  sram_alloc_pkg::rel_req_t             rel
);
    import sram_alloc_pkg::*;

    // The free-page counters are 11 bits wide.
    if (PAGES_PER_SRAM >= 2048) begin : g_size_check
        $error("PAGES_PER_SRAM does not fit the page counter.");
    end

    // Free pages per bank and packets per bank and port.
    pages_t     free_pages [NUM_SRAMS];
    pkt_count_t pkt_cnt    [NUM_SRAMS][NUM_PORTS];

    // Values for the next edge.
    pages_t     free_next [NUM_SRAMS];
    pkt_count_t cnt_next  [NUM_SRAMS][NUM_PORTS];

    // --------------------
    // Lookup.
    // --------------------

    // The matcher reads the bank under scan in the same cycle.
    // A locked bank is out, whatever space it still has.
    assign accessible    = !sram_lock[match_sram];
    assign free_space    = free_pages[match_sram];
    assign packet_amount = pkt_cnt[match_sram][cur_port];

    // --------------------
    // Updates.
    // --------------------

    // The commit is applied first and the release on top of it.
    // Both land when they hit the same bank in one cycle.
    always_comb begin
        free_next = free_pages;
        cnt_next  = pkt_cnt;
        if (commit_valid) begin
            free_next[commit.sram] = free_next[commit.sram] - commit.pages;
            cnt_next[commit.sram][commit_port] =
                cnt_next[commit.sram][commit_port] + pkt_count_t'(1);
        end
        if (rel_valid) begin
            free_next[rel.sram] = free_next[rel.sram] + rel.pages;
            cnt_next[rel.sram][rel.port] = cnt_next[rel.sram][rel.port] - pkt_count_t'(1);
        end
    end

    // After reset every bank is empty.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SRAMS; i++) begin
                free_pages[i] <= pages_t'(PAGES_PER_SRAM);
                for (int p = 0; p < NUM_PORTS; p++) begin
                    pkt_cnt[i][p] <= '0;
                end
            end
        end else begin
            free_pages <= free_next;
            pkt_cnt    <= cnt_next;
        end
    end

    // A release must return a packet that the bank really holds.
    a_rel_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        rel_valid |-> pkt_cnt[rel.sram][rel.port] != '0);

    // The matcher checked the space, so a commit always fits the bank.
    a_commit_fits : assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> commit.pages <= free_pages[commit.sram]);

endmodule

`default_nettype wire

// File: sram_alloc_pkg.sv
`default_nettype none

package sram_alloc_pkg;

    // --------------------
    // Switch geometry.
    // --------------------

    // The bank id is five bits wide, so these two counts are tied to the encoding.
    localparam int NUM_SRAMS = 32;
    localparam int NUM_PORTS = 4;

    // --------------------
    // Widths with a meaning.
    // --------------------

    // Bank index used by the scanner, the table and the grant.
    typedef logic [4:0] sram_id_t;

    // Best-bank code of the matcher, one bit wider than a bank index.
    typedef logic [5:0] best_sram_t;

    // Output port of the switch.
    typedef logic [1:0] port_id_t;

    // Packet length counted in half-words.
    typedef logic [8:0] pkt_len_t;

    // Free space of a bank in pages of 8 half-words.
    typedef logic [10:0] pages_t;

    // Number of packets that one port keeps in one bank.
    typedef logic [8:0] pkt_count_t;

    // Match tick and its run-time threshold.
    typedef logic [4:0] tick_t;

    // The best-bank code used while no candidate has been found yet.
    localparam best_sram_t NO_SRAM = best_sram_t'(NUM_SRAMS);

    // --------------------
    // Bus payloads.
    // --------------------

    // Write request from the ingress side.
    typedef struct packed {
        pkt_len_t length;
        port_id_t port;
    } wr_req_t;

    // Granted bank and the pages reserved in it.
    typedef struct packed {
        sram_id_t sram;
        pages_t   pages;
    } wr_grant_t;

    // Pages and one packet handed back when a packet leaves a bank.
    typedef struct packed {
        sram_id_t sram;
        port_id_t port;
        pages_t   pages;
    } rel_req_t;

    // Request and grant sequencing of the allocation controller.
    typedef enum logic [1:0] {
        alloc_idle,
        alloc_match,
        alloc_grant,
        alloc_commit
    } alloc_state_t;

    // A packet takes its length divided by 8, rounded down, plus one page.
    function automatic pages_t pages_needed(input pkt_len_t length);
        return pages_t'(length[8:3]) + pages_t'(1);
    endfunction

endpackage

`default_nettype wire
